// ==== radio_board_params.svh ====
`ifndef RADIO_BOARD_PARAMS_SVH
`define RADIO_BOARD_PARAMS_SVH

// Data widths
`define ADC_W                14
`define SAMPLE_W             16
`define LED_W                6
`define LED_ACTIVE_LOW_MASK  6'b011111   // All but LED 5 are active low

// SPI fan-out and SCLK half period in dsp_clk cycles
`define SPI_NDEV             4
`define SPI_DIV              2

// Watchdog counter width
`define WDOG_W               6

// Register offsets on the 5-bit AXI4-Lite address
`define REG_CTRL             5'h00
`define REG_LEDS             5'h04
`define REG_DAC_CONST        5'h08
`define REG_STATUS           5'h0C
`define REG_SPI              5'h10

`endif

// ==== radio_board_pkg.sv ====
`default_nettype none

package radio_board_pkg;

   // REG_SPI word, command when written and status when read
   typedef union packed {
      struct packed {
         logic [21:0] zero;
         logic [1:0]  dev;       // Target device
         logic [7:0]  tx_byte;
      } cmd;
      struct packed {
         logic        busy;
         logic [22:0] zero;
         logic [7:0]  rx_byte;   // Last byte shifted in
      } stat;
   } spi_word_u;

endpackage

`default_nettype wire

// ==== radio_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "radio_board_params.svh"

// Conditioned ADC samples, new values every cycle
interface sample_if;
   logic [`SAMPLE_W-1:0] sample_a;
   logic [`SAMPLE_W-1:0] sample_b;
   logic                 ovf_a;
   logic                 ovf_b;

   modport source
   (
      output sample_a, sample_b, ovf_a, ovf_b
   );

   modport sink
   (
      input sample_a, sample_b, ovf_a, ovf_b
   );
endinterface

// Byte transfer request between register bank and SPI engine
interface spi_ctrl_if;
   logic                       start;     // One-cycle pulse
   radio_board_pkg::spi_word_u cmd;
   logic                       busy;
   logic [7:0]                 rx_byte;

   modport master
   (
      output start, cmd,
      input  busy, rx_byte
   );

   modport slave
   (
      input  start, cmd,
      output busy, rx_byte
   );
endinterface

`default_nettype wire

// ==== ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "radio_board_params.svh"

module ctrl_regs
(
   input  wire                dsp_clk,
   input  wire                rst_i,
   input  wire  [4:0]         s_axi_awaddr_i,
   input  wire                s_axi_awvalid_i,
   output logic               s_axi_awready_o,
   input  wire  [31:0]        s_axi_wdata_i,
   input  wire                s_axi_wvalid_i,
   output logic               s_axi_wready_o,
   output logic [1:0]         s_axi_bresp_o,
   output logic               s_axi_bvalid_o,
   input  wire                s_axi_bready_i,
   input  wire  [4:0]         s_axi_araddr_i,
   input  wire                s_axi_arvalid_i,
   output logic               s_axi_arready_o,
   output logic [31:0]        s_axi_rdata_o,
   output logic [1:0]         s_axi_rresp_o,
   output logic               s_axi_rvalid_o,
   input  wire                s_axi_rready_i,
   sample_if.sink             smp,
   spi_ctrl_if.master         spi,
   output logic [1:0]         adc_on_o,
   output logic [1:0]         adc_oe_o,
   output logic [1:0]         dac_src_adc_o,
   output logic [31:0]        dac_const_o,
   output logic [`LED_W-1:0]  leds_o,
   output logic               wdi_o
);

   logic [6:0]                 ctrl_q;
   logic [`LED_W-1:0]          leds_q;
   logic [31:0]                dac_const_q;
   logic [1:0]                 sticky_q;
   logic [`WDOG_W-1:0]         wdog_q;
   logic                       wr_en;
   logic                       rd_en;
   logic                       spi_go;
   radio_board_pkg::spi_word_u wr_word;
   radio_board_pkg::spi_word_u spi_stat;

   // Address and data must arrive together
   assign wr_en  = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o;
   assign rd_en  = s_axi_arvalid_i && s_axi_arready_o;
   assign spi_go = wr_en && (s_axi_awaddr_i == `REG_SPI) && !spi.busy && !spi.start;

   assign s_axi_awready_o = wr_en;
   assign s_axi_wready_o  = wr_en;
   assign s_axi_arready_o = !s_axi_rvalid_o;
   assign s_axi_bresp_o   = 2'b00;  // OKAY
   assign s_axi_rresp_o   = 2'b00;

   assign wr_word = s_axi_wdata_i;

   always_comb
   begin
      spi_stat              = '0;
      spi_stat.stat.busy    = spi.busy;
      spi_stat.stat.rx_byte = spi.rx_byte;
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         ctrl_q         <= '0;
         leds_q         <= '0;
         dac_const_q    <= '0;
         s_axi_bvalid_o <= 1'b0;
         spi.start      <= 1'b0;
      end
      else
      begin
         spi.start <= spi_go;   // Busy SPI writes are acked and dropped
         if (wr_en)
         begin
            s_axi_bvalid_o <= 1'b1;
            case (s_axi_awaddr_i)
               `REG_CTRL:      ctrl_q      <= s_axi_wdata_i[6:0];
               `REG_LEDS:      leds_q      <= s_axi_wdata_i[`LED_W-1:0];
               `REG_DAC_CONST: dac_const_q <= s_axi_wdata_i;
               default: ;
            endcase
         end
         else if (s_axi_bready_i)
            s_axi_bvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge dsp_clk)
   begin
      if (spi_go)
      begin
         spi.cmd.cmd.zero    <= '0;
         spi.cmd.cmd.dev     <= wr_word.cmd.dev;
         spi.cmd.cmd.tx_byte <= wr_word.cmd.tx_byte;
      end
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         sticky_q       <= '0;
         s_axi_rvalid_o <= 1'b0;
      end
      else
      begin
         // A hit in the clearing cycle survives the read
         if (rd_en && s_axi_araddr_i == `REG_STATUS)
            sticky_q <= {smp.ovf_b, smp.ovf_a};
         else
            sticky_q <= sticky_q | {smp.ovf_b, smp.ovf_a};

         if (rd_en)
            s_axi_rvalid_o <= 1'b1;
         else if (s_axi_rready_i)
            s_axi_rvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rd_en)
      begin
         case (s_axi_araddr_i)
            `REG_CTRL:      s_axi_rdata_o <= {25'd0, ctrl_q};
            `REG_LEDS:      s_axi_rdata_o <= {{(32-`LED_W){1'b0}}, leds_q};
            `REG_DAC_CONST: s_axi_rdata_o <= dac_const_q;
            `REG_STATUS:    s_axi_rdata_o <= {29'd0, spi.busy, sticky_q};
            `REG_SPI:       s_axi_rdata_o <= spi_stat;
            default:        s_axi_rdata_o <= '0;
         endcase
      end
   end

   // Watchdog runs only once software reports config done
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i || !ctrl_q[6])
         wdog_q <= '0;
      else
         wdog_q <= wdog_q + 1'b1;
   end

   assign wdi_o         = wdog_q[`WDOG_W-1];
   assign adc_on_o      = ctrl_q[1:0];
   assign adc_oe_o      = ctrl_q[3:2];
   assign dac_src_adc_o = ctrl_q[5:4];   // 1 selects ADC loopback
   assign dac_const_o   = dac_const_q;
   assign leds_o        = leds_q;

endmodule

`default_nettype wire

// ==== adc_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "radio_board_params.svh"

module adc_frontend
(
   input  wire              dsp_clk,
   input  wire              rst_i,
   input  wire [`ADC_W-1:0] adc_a_i,
   input  wire [`ADC_W-1:0] adc_b_i,
   input  wire              adc_ovf_a_i,
   input  wire              adc_ovf_b_i,
   sample_if.source         smp
);

   // Index 0 is channel A, 1 is channel B
   logic [1:0][`ADC_W-1:0] raw_q1;
   logic [1:0][`ADC_W-1:0] raw_q2;
   logic [1:0]             ovf_q1;
   logic [1:0]             ovf_q2;

   always_ff @(posedge dsp_clk)
   begin
      raw_q1 <= {adc_b_i, adc_a_i};
      raw_q2 <= raw_q1;
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         ovf_q1 <= '0;
         ovf_q2 <= '0;
      end
      else
      begin
         ovf_q1 <= {adc_ovf_b_i, adc_ovf_a_i};
         ovf_q2 <= ovf_q1;
      end
   end

   // Two's complement sign extension
   assign smp.sample_a = {{(`SAMPLE_W-`ADC_W){raw_q2[0][`ADC_W-1]}}, raw_q2[0]};
   assign smp.sample_b = {{(`SAMPLE_W-`ADC_W){raw_q2[1][`ADC_W-1]}}, raw_q2[1]};
   assign smp.ovf_a    = ovf_q2[0];
   assign smp.ovf_b    = ovf_q2[1];

endmodule

`default_nettype wire

// ==== dac_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "radio_board_params.svh"

module dac_path
(
   input  wire                   dsp_clk,
   input  wire                   rst_i,
   sample_if.sink                smp,
   input  wire  [1:0]            dac_src_adc_i,
   input  wire  [2*`SAMPLE_W-1:0] dac_const_i,
   output logic [`SAMPLE_W-1:0]  dac_a_o,
   output logic [`SAMPLE_W-1:0]  dac_b_o
);

   // Output register, rising edge
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end
      else
      begin
         dac_a_o <= dac_src_adc_i[0] ? smp.sample_a : dac_const_i[`SAMPLE_W-1:0];
         dac_b_o <= dac_src_adc_i[1] ? smp.sample_b
                                     : dac_const_i[2*`SAMPLE_W-1:`SAMPLE_W];
      end
   end

endmodule

`default_nettype wire

// ==== spi_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "radio_board_params.svh"

module spi_port
(
   input  wire                  dsp_clk,
   input  wire                  rst_i,
   spi_ctrl_if.slave            spi,
   output logic [`SPI_NDEV-1:0] spi_sen_o,
   output logic [`SPI_NDEV-1:0] spi_sclk_o,
   output logic [`SPI_NDEV-1:0] spi_sdi_o,
   input  wire  [`SPI_NDEV-1:0] spi_sdo_i
);

   localparam int DIV_W = $clog2(`SPI_DIV) + 1;

   logic             busy_q;
   logic             sclk_q;
   logic [DIV_W-1:0] div_q;
   logic [2:0]       bit_q;
   logic [7:0]       tx_q;
   logic [7:0]       rx_q;
   logic [1:0]       dev_q;
   logic             half_done;
   logic             miso;
   logic [`SPI_NDEV-1:0] dev_sel;

   assign half_done = (div_q == DIV_W'(`SPI_DIV - 1));
   assign miso      = spi_sdo_i[dev_q];   // Only the addressed device is heard

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         busy_q <= 1'b0;
         sclk_q <= 1'b0;
         div_q  <= '0;
         bit_q  <= '0;
      end
      else if (!busy_q)
      begin
         if (spi.start)
         begin
            busy_q <= 1'b1;
            div_q  <= '0;
            bit_q  <= '0;
         end
      end
      else if (half_done)
      begin
         div_q  <= '0;
         sclk_q <= !sclk_q;
         if (sclk_q)                        // Falling edge
         begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7)
               busy_q <= 1'b0;              // CS rises with the last fall
         end
      end
      else
         div_q <= div_q + 1'b1;
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
         rx_q <= '0;
      else if (busy_q && half_done && !sclk_q)
         rx_q <= {rx_q[6:0], miso};         // Sample on rising edge
   end

   always_ff @(posedge dsp_clk)
   begin
      if (!busy_q && spi.start)
      begin
         tx_q  <= spi.cmd.cmd.tx_byte;
         dev_q <= spi.cmd.cmd.dev;
      end
      else if (busy_q && half_done && sclk_q)
         tx_q <= {tx_q[6:0], 1'b0};         // Next bit after the fall
   end

   always_comb
   begin
      dev_sel        = '0;
      dev_sel[dev_q] = busy_q;
   end

   // Idle devices see CS high, SCLK and SDI low
   assign spi_sen_o  = ~dev_sel;
   assign spi_sclk_o = dev_sel & {`SPI_NDEV{sclk_q}};
   assign spi_sdi_o  = dev_sel & {`SPI_NDEV{tx_q[7]}};

   assign spi.busy    = busy_q;
   assign spi.rx_byte = rx_q;

endmodule

`default_nettype wire

// ==== radio_board.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "radio_board_params.svh"

module radio_board
(
   input  wire                  dsp_clk,
   input  wire                  rst_i,
   input  wire  [4:0]           s_axi_awaddr_i,
   input  wire                  s_axi_awvalid_i,
   output logic                 s_axi_awready_o,
   input  wire  [31:0]          s_axi_wdata_i,
   input  wire                  s_axi_wvalid_i,
   output logic                 s_axi_wready_o,
   output logic [1:0]           s_axi_bresp_o,
   output logic                 s_axi_bvalid_o,
   input  wire                  s_axi_bready_i,
   input  wire  [4:0]           s_axi_araddr_i,
   input  wire                  s_axi_arvalid_i,
   output logic                 s_axi_arready_o,
   output logic [31:0]          s_axi_rdata_o,
   output logic [1:0]           s_axi_rresp_o,
   output logic                 s_axi_rvalid_o,
   input  wire                  s_axi_rready_i,
   input  wire  [`ADC_W-1:0]    adc_a_i,
   input  wire  [`ADC_W-1:0]    adc_b_i,
   input  wire                  adc_ovf_a_i,
   input  wire                  adc_ovf_b_i,
   output logic                 adc_pdn_a_o,
   output logic                 adc_pdn_b_o,
   output logic                 adc_oen_a_o,
   output logic                 adc_oen_b_o,
   output logic [`SAMPLE_W-1:0] dac_a_o,
   output logic [`SAMPLE_W-1:0] dac_b_o,
   output logic [`SPI_NDEV-1:0] spi_sen_o,
   output logic [`SPI_NDEV-1:0] spi_sclk_o,
   output logic [`SPI_NDEV-1:0] spi_sdi_o,
   input  wire  [`SPI_NDEV-1:0] spi_sdo_i,
   output logic [`LED_W-1:0]    leds_o,
   output logic                 wdi_o
);

   logic [1:0]        adc_on;
   logic [1:0]        adc_oe;
   logic [1:0]        dac_src_adc;
   logic [31:0]       dac_const;
   logic [`LED_W-1:0] leds_int;

   sample_if   smp ();
   spi_ctrl_if spi ();

   // AXI and clock/reset ports share names with the top level
   ctrl_regs i_ctrl_regs
   (
      .smp           (smp),
      .spi           (spi),
      .adc_on_o      (adc_on),
      .adc_oe_o      (adc_oe),
      .dac_src_adc_o (dac_src_adc),
      .dac_const_o   (dac_const),
      .leds_o        (leds_int),
      .*
   );

   adc_frontend i_adc_frontend
   (
      .dsp_clk     (dsp_clk),
      .rst_i       (rst_i),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .adc_ovf_a_i (adc_ovf_a_i),
      .adc_ovf_b_i (adc_ovf_b_i),
      .smp         (smp)
   );

   dac_path i_dac_path
   (
      .dsp_clk       (dsp_clk),
      .rst_i         (rst_i),
      .smp           (smp),
      .dac_src_adc_i (dac_src_adc),
      .dac_const_i   (dac_const),
      .dac_a_o       (dac_a_o),
      .dac_b_o       (dac_b_o)
   );

   spi_port i_spi_port
   (
      .dsp_clk    (dsp_clk),
      .rst_i      (rst_i),
      .spi        (spi),
      .spi_sen_o  (spi_sen_o),
      .spi_sclk_o (spi_sclk_o),
      .spi_sdi_o  (spi_sdi_o),
      .spi_sdo_i  (spi_sdo_i)
   );

   // ADC control pins are active low
   assign adc_pdn_a_o = ~adc_on[0];
   assign adc_pdn_b_o = ~adc_on[1];
   assign adc_oen_a_o = ~adc_oe[0];
   assign adc_oen_b_o = ~adc_oe[1];

   assign leds_o = leds_int ^ `LED_ACTIVE_LOW_MASK;   // Per-LED polarity

endmodule

`default_nettype wire

// ==== radio_board_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "radio_board_params.svh"

module radio_board_tb;

   localparam int AXI_CYC        = 4;   // Cycles per register access
   localparam int N_SAMPLES      = 40;
   localparam int RUN_CYCLES     = 80 * AXI_CYC + 2 * N_SAMPLES * 8
                                 + `SPI_NDEV * (16 * `SPI_DIV + 20 * AXI_CYC)
                                 + 200 + (1 << `WDOG_W);
   localparam int TIMEOUT_CYCLES = 10 * RUN_CYCLES;

   logic                 dsp_clk;
   logic                 rst_i;
   logic [4:0]           s_axi_awaddr_i;
   logic                 s_axi_awvalid_i;
   logic                 s_axi_awready_o;
   logic [31:0]          s_axi_wdata_i;
   logic                 s_axi_wvalid_i;
   logic                 s_axi_wready_o;
   logic [1:0]           s_axi_bresp_o;
   logic                 s_axi_bvalid_o;
   logic                 s_axi_bready_i;
   logic [4:0]           s_axi_araddr_i;
   logic                 s_axi_arvalid_i;
   logic                 s_axi_arready_o;
   logic [31:0]          s_axi_rdata_o;
   logic [1:0]           s_axi_rresp_o;
   logic                 s_axi_rvalid_o;
   logic                 s_axi_rready_i;
   logic [`ADC_W-1:0]    adc_a_i;
   logic [`ADC_W-1:0]    adc_b_i;
   logic                 adc_ovf_a_i;
   logic                 adc_ovf_b_i;
   logic                 adc_pdn_a_o;
   logic                 adc_pdn_b_o;
   logic                 adc_oen_a_o;
   logic                 adc_oen_b_o;
   logic [`SAMPLE_W-1:0] dac_a_o;
   logic [`SAMPLE_W-1:0] dac_b_o;
   logic [`SPI_NDEV-1:0] spi_sen_o;
   logic [`SPI_NDEV-1:0] spi_sclk_o;
   logic [`SPI_NDEV-1:0] spi_sdi_o;
   logic [`SPI_NDEV-1:0] spi_sdo_i;
   logic [`LED_W-1:0]    leds_o;
   logic                 wdi_o;

   int                     errors;
   int                     checks;
   int                     cycle_cnt;
   string                  test_name;
   logic [2:0][`ADC_W-1:0] hist_a;        // ADC pins seen at the last 3 edges
   logic [2:0][`ADC_W-1:0] hist_b;
   logic                   dac_chk_en;
   logic [1:0]             exp_src;
   logic [31:0]            exp_const;
   logic                   spi_watch;
   int                     spi_dev_exp;
   logic [`SPI_NDEV-1:0]   prev_sen;
   logic [`SPI_NDEV-1:0]   prev_sclk;
   logic [7:0]             mosi_sr [`SPI_NDEV];
   logic [7:0]             miso_sr [`SPI_NDEV];
   logic [7:0]             dev_rx [`SPI_NDEV];
   logic [7:0]             dev_tx [`SPI_NDEV];
   int                     bit_cnt [`SPI_NDEV];
   int                     bits_seen [`SPI_NDEV];

   radio_board i_radio_board (.*);

   initial
   begin
      dsp_clk = 1'b0;
      forever #4 dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles, the DUT stopped responding (errors: %0d)",
                  cycle_cnt, errors);
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("Error %s: expected 0x%0h, actual 0x%0h at %0t", name, expected, actual,
                  $time);
      end
   endtask

   // Expected DAC word, constant half or the ADC value in two's complement
   function automatic logic [`SAMPLE_W-1:0] exp_dac(input logic src_adc,
                                                    input logic [`SAMPLE_W-1:0] const_half,
                                                    input logic [`ADC_W-1:0] adc_raw);
      int value;
      value = adc_raw;
      if (adc_raw[`ADC_W-1])
         value = value - (1 << `ADC_W);    // Sign bit carries negative weight
      if (src_adc)
         return value[`SAMPLE_W-1:0];
      return const_half;
   endfunction

   // Pin level per LED, inverted where the LED is active low
   function automatic logic [`LED_W-1:0] led_pins(input logic [`LED_W-1:0] reg_bits);
      logic [`LED_W-1:0] low_mask;
      logic [`LED_W-1:0] pins;
      low_mask = `LED_ACTIVE_LOW_MASK;
      for (int i = 0; i < `LED_W; i++)
         pins[i] = low_mask[i] ? !reg_bits[i] : reg_bits[i];
      return pins;
   endfunction

   always @(posedge dsp_clk)
   begin
      hist_a <= {hist_a[1:0], adc_a_i};
      hist_b <= {hist_b[1:0], adc_b_i};
   end

   // ADC pin to DAC pin is 3 cycles in loopback
   always @(negedge dsp_clk)
   begin
      if (dac_chk_en)
      begin
         check({test_name, " dac_a"}, 32'(exp_dac(exp_src[0], exp_const[15:0], hist_a[2])),
               32'(dac_a_o));
         check({test_name, " dac_b"}, 32'(exp_dac(exp_src[1], exp_const[31:16], hist_b[2])),
               32'(dac_b_o));
      end
   end

   // SPI mode-0 devices, one per chip select
   always @(negedge dsp_clk)
   begin
      for (int j = 0; j < `SPI_NDEV; j++)
      begin
         if (prev_sen[j] && !spi_sen_o[j])
         begin
            dev_tx[j]    = 8'($urandom);          // New reply byte per transfer
            miso_sr[j]   = dev_tx[j];
            bit_cnt[j]   = 0;
            spi_sdo_i[j] = dev_tx[j][7];
         end
         else if (!spi_sen_o[j])
         begin
            if (!prev_sclk[j] && spi_sclk_o[j])
            begin
               mosi_sr[j] = {mosi_sr[j][6:0], spi_sdi_o[j]};
               bit_cnt[j] = bit_cnt[j] + 1;
            end
            else if (prev_sclk[j] && !spi_sclk_o[j])
            begin
               miso_sr[j]   = {miso_sr[j][6:0], 1'b0};
               spi_sdo_i[j] = miso_sr[j][7];
            end
         end
         else if (!prev_sen[j])
         begin
            dev_rx[j]    = mosi_sr[j];
            bits_seen[j] = bit_cnt[j];
            spi_sdo_i[j] = 1'b1;                  // Idle pull-up
         end
         if (spi_watch && j != spi_dev_exp)
         begin
            check($sformatf("%s idle sen%0d", test_name, j), 1, spi_sen_o[j]);
            check($sformatf("%s idle sclk%0d", test_name, j), 0, spi_sclk_o[j]);
            check($sformatf("%s idle sdi%0d", test_name, j), 0, spi_sdi_o[j]);
         end
      end
      prev_sen  = spi_sen_o;
      prev_sclk = spi_sclk_o;
   end

   task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
      int accepts;
      accepts = 0;
      @(negedge dsp_clk);
      s_axi_awaddr_i  = addr;
      s_axi_wdata_i   = data;
      s_axi_awvalid_i = 1'b1;
      s_axi_wvalid_i  = 1'b1;
      do
      begin
         @(posedge dsp_clk);
         if (s_axi_awready_o && s_axi_wready_o)
            accepts++;                            // Address and data taken together
         @(negedge dsp_clk);
      end
      while (!s_axi_bvalid_o);
      check({test_name, " bresp"}, 0, s_axi_bresp_o);
      check({test_name, " aw/w accepts"}, 1, accepts);
      check({test_name, " aw/w ready after accept"}, 0, {s_axi_awready_o, s_axi_wready_o});
      s_axi_awvalid_i = 1'b0;
      s_axi_wvalid_i  = 1'b0;
      s_axi_bready_i  = 1'b1;
      @(negedge dsp_clk);
      s_axi_bready_i  = 1'b0;
   endtask

   task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
      int accepts;
      accepts = 0;
      @(negedge dsp_clk);
      s_axi_araddr_i  = addr;
      s_axi_arvalid_i = 1'b1;
      do
      begin
         @(posedge dsp_clk);
         if (s_axi_arready_o)
            accepts++;
         @(negedge dsp_clk);
      end
      while (!s_axi_rvalid_o);
      data = s_axi_rdata_o;
      check({test_name, " rresp"}, 0, s_axi_rresp_o);
      check({test_name, " ar accepts"}, 1, accepts);
      check({test_name, " arready while pending"}, 0, s_axi_arready_o);
      s_axi_arvalid_i = 1'b0;
      s_axi_rready_i  = 1'b1;
      @(negedge dsp_clk);
      s_axi_rready_i  = 1'b0;
   endtask

   task automatic reset_and_regs();
      logic [31:0]       rd;
      logic [`LED_W-1:0] led_val;
      logic [4:0]        reg_addr [5];
      reg_addr  = '{`REG_CTRL, `REG_LEDS, `REG_DAC_CONST, `REG_STATUS, `REG_SPI};
      test_name = "reset";
      for (int i = 0; i < 5; i++)
      begin
         axi_read(reg_addr[i], rd);
         check($sformatf("reset reg 0x%02h", reg_addr[i]), 0, rd);
      end
      check("reset leds", `LED_ACTIVE_LOW_MASK, leds_o);
      check("reset pdn", 2'b11, {adc_pdn_b_o, adc_pdn_a_o});
      check("reset oen", 2'b11, {adc_oen_b_o, adc_oen_a_o});
      check("reset spi_sen", {`SPI_NDEV{1'b1}}, spi_sen_o);
      check("reset spi_sclk_sdi", 0, {spi_sclk_o, spi_sdi_o});
      check("reset wdi", 0, wdi_o);
      check("reset dac", 0, {dac_b_o, dac_a_o});
      test_name = "regs";
      axi_write(`REG_CTRL, 32'h05);                // ADC A on and driving only
      axi_read(`REG_CTRL, rd);
      check("regs ctrl", 32'h05, rd);
      check("regs pdn", 2'b10, {adc_pdn_b_o, adc_pdn_a_o});
      check("regs oen", 2'b10, {adc_oen_b_o, adc_oen_a_o});
      axi_write(`REG_CTRL, 32'h0F);
      check("regs pdn all", 2'b00, {adc_pdn_b_o, adc_pdn_a_o});
      check("regs oen all", 2'b00, {adc_oen_b_o, adc_oen_a_o});
      repeat (4)
      begin
         led_val = `LED_W'($urandom);
         axi_write(`REG_LEDS, 32'(led_val));
         axi_read(`REG_LEDS, rd);
         check("regs leds", 32'(led_val), rd);
         check("regs led pins", led_pins(led_val), leds_o);
      end
   endtask

   task automatic dac_constants();
      logic [31:0] rd;
      logic [31:0] val;
      test_name  = "dac_const";
      dac_chk_en = 1'b0;
      exp_src    = 2'b00;
      repeat (8)
      begin
         val        = $urandom;
         dac_chk_en = 1'b0;
         axi_write(`REG_DAC_CONST, val);
         exp_const  = val;
         dac_chk_en = 1'b1;
         axi_read(`REG_DAC_CONST, rd);
         check("dac_const readback", val, rd);
      end
      dac_chk_en = 1'b0;
   endtask

   task automatic dac_loopback(input logic [1:0] src, input int n);
      int hold;
      test_name  = (src == 2'b11) ? "dac_loopback" : "dac_mixed";
      dac_chk_en = 1'b0;
      axi_write(`REG_CTRL, {25'd0, 1'b0, src, 4'hF});
      exp_src    = src;
      dac_chk_en = 1'b1;
      for (int i = 0; i < n; i++)
      begin
         @(negedge dsp_clk);
         adc_a_i = `ADC_W'($urandom);
         adc_b_i = `ADC_W'($urandom);
         hold    = 4 + int'($urandom % 4);
         repeat (hold - 1) @(negedge dsp_clk);
      end
      dac_chk_en = 1'b0;
   endtask

   task automatic pulse_ovf(input logic [1:0] which);
      @(negedge dsp_clk);
      adc_ovf_a_i = which[0];
      adc_ovf_b_i = which[1];
      @(negedge dsp_clk);
      adc_ovf_a_i = 1'b0;
      adc_ovf_b_i = 1'b0;
      repeat (4) @(negedge dsp_clk);        // Flag lands 3 cycles after the pin
   endtask

   task automatic overflow_flags();
      logic [31:0] rd;
      test_name = "sticky_ovf";
      for (int k = 1; k < 4; k++)
      begin
         pulse_ovf(2'(k));
         axi_read(`REG_STATUS, rd);
         check($sformatf("sticky_ovf set %0d", k), 32'(k), rd);
         axi_read(`REG_STATUS, rd);
         check($sformatf("sticky_ovf clear %0d", k), 0, rd);
      end
   endtask

   task automatic spi_transfers();
      logic [31:0]                rd;
      logic [7:0]                 tx;
      radio_board_pkg::spi_word_u spi_word;
      for (int d = 0; d < `SPI_NDEV; d++)
      begin
         test_name            = $sformatf("spi_dev%0d", d);
         tx                   = 8'($urandom);
         spi_word             = '0;
         spi_word.cmd.dev     = 2'(d);
         spi_word.cmd.tx_byte = tx;
         spi_dev_exp          = d;
         spi_watch            = 1'b1;
         axi_write(`REG_SPI, spi_word);
         axi_read(`REG_SPI, rd);
         spi_word = rd;
         while (spi_word.stat.busy)
         begin
            axi_read(`REG_SPI, rd);
            spi_word = rd;
         end
         spi_watch = 1'b0;
         check({test_name, " mosi"}, 32'(tx), 32'(dev_rx[d]));
         check({test_name, " bits"}, 8, bits_seen[d]);
         check({test_name, " rx_word"}, {24'd0, dev_tx[d]}, rd);
      end
   endtask

   task automatic watchdog_and_bus();
      logic [31:0] rd;
      int          high_cnt;
      int          toggles;
      logic        last;
      test_name = "wdog";
      high_cnt  = 0;
      repeat (200)
      begin
         @(negedge dsp_clk);
         if (wdi_o)
            high_cnt++;
      end
      check("wdog idle highs", 0, high_cnt);
      axi_write(`REG_CTRL, 32'h40);             // config_done
      toggles = 0;
      last    = wdi_o;
      repeat ((1 << `WDOG_W) + 8)
      begin
         @(negedge dsp_clk);
         if (wdi_o != last)
            toggles++;
         last = wdi_o;
      end
      check("wdog toggles seen", 1, 32'(toggles >= 2));
      test_name = "unmapped";
      axi_write(5'h14, 32'hFFFF_FFFF);
      for (int a = 5'h14; a <= 5'h1C; a += 4)
      begin
         axi_read(5'(a), rd);
         check($sformatf("unmapped 0x%02h", a), 0, rd);
      end
   endtask

   initial
   begin
      void'($urandom(57));
      errors          = 0;
      checks          = 0;
      cycle_cnt       = 0;
      test_name       = "init";
      rst_i           = 1'b1;
      s_axi_awaddr_i  = '0;
      s_axi_awvalid_i = 1'b0;
      s_axi_wdata_i   = '0;
      s_axi_wvalid_i  = 1'b0;
      s_axi_bready_i  = 1'b0;
      s_axi_araddr_i  = '0;
      s_axi_arvalid_i = 1'b0;
      s_axi_rready_i  = 1'b0;
      adc_a_i         = '0;
      adc_b_i         = '0;
      adc_ovf_a_i     = 1'b0;
      adc_ovf_b_i     = 1'b0;
      spi_sdo_i       = '1;
      dac_chk_en      = 1'b0;
      exp_src         = 2'b00;
      exp_const       = '0;
      spi_watch       = 1'b0;
      spi_dev_exp     = 0;
      prev_sen        = '1;
      prev_sclk       = '0;
      repeat (3) @(negedge dsp_clk);
      rst_i = 1'b0;

      reset_and_regs();
      dac_constants();
      dac_loopback(2'b11, N_SAMPLES);
      dac_loopback(2'b01, N_SAMPLES / 2);
      overflow_flags();
      spi_transfers();
      watchdog_and_bus();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== radio_board.f ====
+incdir+.
radio_board_pkg.sv
radio_ifs.sv
ctrl_regs.sv
adc_frontend.sv
dac_path.sv
spi_port.sv
radio_board.sv
radio_board_tb.sv

// ==== Makefile ====
TOP = radio_board_tb

all: run

obj_dir/V$(TOP): radio_board.f *.sv *.svh
	verilator --binary --timing -Wno-fatal -f radio_board.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only --timing -f radio_board.f --top-module radio_board

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
